// File: Makefile
# Verilator build and run of the panel control testbench

VERILATOR ?= verilator
TOP       ?= tb_panel_ctl
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_clock_gen.sv
/*
  testbench clock and reset, 8 ns period.
  reset held low for the first 2 rising edges.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic cs,
  output logic arst_n
);

  initial
  begin
    cs     = 1'b0;
    arst_n = 1'b0;
    repeat (2) @(posedge cs);
    #1 arst_n = 1'b1;
  end

  always #4 cs = ~cs;

endmodule

`default_nettype wire

// File: dv/tb_panel_ctl.sv
/*
  table-driven testbench for panel_ctl_top, spi mode 0 host on the cs grid.
  read frames rewrite port_sel with the model value so a read never disturbs it.
  first error stops the run.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_panel_ctl;

  localparam int hb_div = 64;
  localparam spi_ctl_pkg::port_vec_t port_pol = 8'h01;
  localparam int half = 4;
  localparam int frame_cyc = 2 * half * spi_ctl_pkg::frame_bits + 24;

  // cycles from a frame's first cs edge to its write strobe
  localparam int wr_lat = 2 * half * spi_ctl_pkg::frame_bits + half + 4;
  // wait after a heartbeat toggle so the next write strobe meets the next pulse
  localparam int hb_align = ((hb_div - 2 - wr_lat) % hb_div + hb_div) % hb_div;

  // entry kinds
  localparam logic [2:0] k_wr = 3'd0, k_rd = 3'd1, k_short = 3'd2;
  localparam logic [2:0] k_pass = 3'd3, k_hb = 3'd4, k_hold = 3'd5;

  typedef struct packed {
    logic [2:0]             kind;
    spi_ctl_pkg::reg_addr_t addr;
    spi_ctl_pkg::reg_data_t data;
    spi_ctl_pkg::reg_data_t exp;
    logic                   chk;   // check register pins after a write
  } entry_t;

  logic                   cs;
  logic                   arst_n;
  spi_ctl_pkg::spi_pins_t host;
  logic                   spi_ss2_n;
  spi_ctl_pkg::port_vec_t port_miso;
  logic                   spi_miso;
  logic [3:0]             led;
  logic                   oe_4094;
  spi_ctl_pkg::port_vec_t port_ss;
  spi_ctl_pkg::port_vec_t port_sclk;
  spi_ctl_pkg::port_vec_t port_mosi;

  entry_t tbl[$];
  logic [31:0] rng = 32'hc9b3;
  int cycles = 0;
  int limit = 0;

  // reference register state
  logic [3:0] m_led = spi_ctl_pkg::led_init;
  logic [7:0] m_port = 8'h00;
  logic [3:0] m_drv = 4'h0;

  tb_clock_gen u_clk (.cs(cs), .arst_n(arst_n));

  panel_ctl_top #(.HEARTBEAT_DIV(hb_div), .PORT_CS_POLARITY(port_pol)) u_dut (
    .cs, .arst_n, .host, .spi_ss2_n, .port_miso, .spi_miso, .led, .oe_4094,
    .port_ss, .port_sclk, .port_mosi
  );

  //////////////////////////////////////////////////
  // failure reporting and compares

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_reg(input spi_ctl_pkg::reg_data_t got,
                           input spi_ctl_pkg::reg_data_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp));
  endtask

  task automatic check_port(input spi_ctl_pkg::port_vec_t got,
                            input spi_ctl_pkg::port_vec_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp));
  endtask

  // timeout counter
  always @(posedge cs)
  begin
    cycles = cycles + 1;
    if ((limit > 0) && (cycles > limit))
      fail_run($sformatf("timeout: run exceeded %0d cycles", limit));
  end

  //////////////////////////////////////////////////
  // reference model

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] rand_byte();
    rng = xorshift(rng);
    return rng[15:8];
  endfunction

  // per bit: both means toggle, clear beats set
  function automatic logic [3:0] bit_rule(input logic [3:0] cur, input logic [7:0] d);
    logic [3:0] res;
    logic any_both;
    any_both = 1'b0;
    for (int b = 0; b < 4; b++)
      if (d[b] && d[b+4])
        any_both = 1'b1;
    for (int b = 0; b < 4; b++)
    begin
      if (any_both)
        res[b] = (d[b] && d[b+4]) ? ~cur[b] : cur[b];
      else if (d[b+4])
        res[b] = 1'b0;
      else if (d[b])
        res[b] = 1'b1;
      else
        res[b] = cur[b];
    end
    return res;
  endfunction

  task automatic model_write(input logic [7:0] a, input logic [7:0] d);
    if (a == spi_ctl_pkg::addr_led)
      m_led = bit_rule(m_led, d);
    else if (a == spi_ctl_pkg::addr_port_sel)
      m_port = d;
    else if (a == spi_ctl_pkg::addr_drv_4094)
      m_drv = bit_rule(m_drv, d);
    else if (a == spi_ctl_pkg::addr_soft_rst)
    begin
      m_led  = 4'h0;
      m_port = 8'h00;
    end
    else if (a == spi_ctl_pkg::addr_pwr_clear)
      m_led = 4'h0;
  endtask

  function automatic logic [7:0] model_read(input logic [7:0] a);
    if (a == spi_ctl_pkg::addr_led)
      return {4'h0, m_led};
    if (a == spi_ctl_pkg::addr_port_sel)
      return m_port;
    if (a == spi_ctl_pkg::addr_drv_4094)
      return {4'h0, m_drv};
    return 8'h00;
  endfunction

  function automatic spi_ctl_pkg::port_vec_t port_hot(input logic [7:0] v);
    if ((v >= 8'd1) && (v <= 8'd8))
      return spi_ctl_pkg::port_vec_t'(1) << (v - 8'd1);
    return '0;
  endfunction

  //////////////////////////////////////////////////
  // table building

  task automatic add_wr(input logic [7:0] a, input logic [7:0] d, input logic chk);
    model_write(a, d);
    tbl.push_back('{kind: k_wr, addr: a, data: d, exp: model_read(a), chk: chk});
  endtask

  task automatic add_rd(input logic [7:0] a);
    logic [7:0] keep;
    keep = (a == spi_ctl_pkg::addr_port_sel) ? m_port : 8'h00;
    tbl.push_back('{kind: k_rd, addr: a, data: keep, exp: model_read(a), chk: 1'b0});
  endtask

  task automatic add_op(input logic [2:0] k, input logic [7:0] a, input logic [7:0] d);
    if (k == k_pass)
      model_write(spi_ctl_pkg::addr_port_sel, d);
    tbl.push_back('{kind: k, addr: a, data: d, exp: model_read(a), chk: 1'b0});
  endtask

  //////////////////////////////////////////////////
  // spi host, pins move 1 ns after the cs edge

  task automatic spi_frame(input int nbits, input logic [15:0] word,
                           output spi_ctl_pkg::reg_data_t rd);
    rd = '0;
    @(posedge cs);
    #1 host.ss_n = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      // a short frame sends the low nbits of the word, msb first
      host.mosi = word[nbits-1-i];
      repeat (half) @(posedge cs);
      #1;
      // byte two readback just before the rising edge
      if (i >= 8)
        rd = {rd[6:0], spi_miso};
      host.sclk = 1'b1;
      repeat (half) @(posedge cs);
      #1 host.sclk = 1'b0;
    end
    repeat (half) @(posedge cs);
    #1 host.ss_n = 1'b1;
    host.mosi = 1'b0;
    // 5 cycle write latency plus margin
    repeat (8) @(posedge cs);
    #1;
  endtask

  task automatic run_pass(input entry_t e);
    spi_ctl_pkg::reg_data_t rd;
    spi_ctl_pkg::port_vec_t hot;
    spi_ctl_pkg::port_vec_t pm;
    spi_ctl_pkg::port_vec_t ss_exp;
    logic                   sel_on;
    logic                   miso_exp;
    spi_frame(16, {spi_ctl_pkg::addr_port_sel, e.data}, rd);
    hot = port_hot(e.data);
    pm  = rand_byte();
    sel_on = (e.data >= 8'd1) && (e.data <= 8'd8);
    miso_exp = 1'b0;
    if (sel_on)
      miso_exp = pm[e.data - 8'd1];
    // selected strobe takes its polarity, the others sit inactive
    ss_exp = (hot & port_pol) | (~hot & ~port_pol);
    @(posedge cs);
    #1;
    port_miso = pm;
    spi_ss2_n = 1'b0;
    host.sclk = 1'b1;
    host.mosi = 1'b1;
    #2;
    check_port(port_sclk, hot, "port_sclk");
    check_port(port_mosi, hot, "port_mosi");
    check_port(port_ss, ss_exp, "port_ss active");
    check_reg({7'b0, spi_miso}, {7'b0, miso_exp}, "port miso return");
    // flip every port miso, the selected one must follow
    port_miso = ~pm;
    #1;
    check_reg({7'b0, spi_miso}, {7'b0, sel_on & ~miso_exp}, "port miso return flipped");
    host.sclk = 1'b0;
    host.mosi = 1'b0;
    #1;
    check_port(port_sclk, '0, "port_sclk low");
    spi_ss2_n = 1'b1;
    #1;
    check_port(port_ss, ~port_pol, "port_ss idle");
    check_reg({7'b0, spi_miso}, 8'h00, "slave miso idle");
  endtask

  task automatic apply(input entry_t e);
    spi_ctl_pkg::reg_data_t rd;
    logic v;
    logic seen;
    case (e.kind)
      k_wr:
      begin
        spi_frame(16, {e.addr, e.data}, rd);
        if (e.chk && (e.addr == spi_ctl_pkg::addr_led))
          check_reg({4'h0, led}, e.exp, "led pins");
        if (e.chk && (e.addr == spi_ctl_pkg::addr_drv_4094))
          check_reg({7'b0, oe_4094}, {7'b0, e.exp[0]}, "oe_4094");
      end
      k_rd:
      begin
        spi_frame(16, {e.addr, e.data}, rd);
        check_reg(rd, e.exp, $sformatf("readback of %0d", e.addr));
      end
      k_short: spi_frame(12, {e.addr, e.data}, rd);
      k_pass: run_pass(e);
      k_hb:
      begin
        v = led[0];
        seen = 1'b0;
        for (int n = 0; (n < 2 * hb_div) && !seen; n++)
        begin
          @(posedge cs);
          #1;
          if (led[0] !== v)
            seen = 1'b1;
        end
        if (!seen)
          fail_run("heartbeat did not toggle led bit 0 in time");
        // next frame's write strobe lands on the same cycle as a heartbeat pulse
        repeat (hb_align) @(posedge cs);
        #1;
      end
      default:
      begin
        // heartbeat off, led must sit still
        for (int n = 0; n < 2 * hb_div; n++)
        begin
          @(posedge cs);
          #1;
          check_reg({4'h0, led}, e.exp, "led hold");
        end
      end
    endcase
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    host      = '{sclk: 1'b0, ss_n: 1'b1, mosi: 1'b0};
    spi_ss2_n = 1'b1;
    port_miso = '0;

    // reset state
    add_rd(spi_ctl_pkg::addr_led);
    add_rd(spi_ctl_pkg::addr_port_sel);
    add_rd(spi_ctl_pkg::addr_drv_4094);
    for (int i = 0; i < 6; i++)
    begin
      add_wr(spi_ctl_pkg::addr_port_sel, rand_byte(), 1'b0);
      add_rd(spi_ctl_pkg::addr_port_sel);
    end
    // led bit 3 kept low here, it starts the heartbeat
    add_wr(spi_ctl_pkg::addr_led, 8'h02, 1'b1);
    add_wr(spi_ctl_pkg::addr_led, 8'h21, 1'b1);
    add_wr(spi_ctl_pkg::addr_led, 8'h33, 1'b1);
    for (int i = 0; i < 4; i++)
    begin
      add_wr(spi_ctl_pkg::addr_led, rand_byte() & 8'h77, 1'b1);
      add_rd(spi_ctl_pkg::addr_led);
    end
    add_wr(spi_ctl_pkg::addr_drv_4094, 8'h01, 1'b1);
    add_wr(spi_ctl_pkg::addr_drv_4094, 8'h0f, 1'b1);
    add_wr(spi_ctl_pkg::addr_drv_4094, 8'h31, 1'b1);
    add_rd(spi_ctl_pkg::addr_drv_4094);
    add_wr(spi_ctl_pkg::addr_drv_4094, 8'hf0, 1'b1);
    for (int i = 0; i < 3; i++)
    begin
      add_wr(spi_ctl_pkg::addr_drv_4094, rand_byte(), 1'b1);
      add_rd(spi_ctl_pkg::addr_drv_4094);
    end
    // clearing commands and a short frame
    add_wr(spi_ctl_pkg::addr_led, 8'h07, 1'b1);
    add_wr(spi_ctl_pkg::addr_port_sel, 8'h05, 1'b0);
    add_wr(spi_ctl_pkg::addr_pwr_clear, 8'h00, 1'b0);
    add_rd(spi_ctl_pkg::addr_led);
    add_rd(spi_ctl_pkg::addr_port_sel);
    add_wr(spi_ctl_pkg::addr_led, 8'h03, 1'b1);
    add_wr(spi_ctl_pkg::addr_drv_4094, 8'h05, 1'b1);
    add_op(k_short, spi_ctl_pkg::addr_soft_rst, 8'h00);
    add_rd(spi_ctl_pkg::addr_led);
    add_rd(spi_ctl_pkg::addr_port_sel);
    add_wr(spi_ctl_pkg::addr_soft_rst, 8'h00, 1'b0);
    add_rd(spi_ctl_pkg::addr_led);
    add_rd(spi_ctl_pkg::addr_port_sel);
    add_rd(spi_ctl_pkg::addr_drv_4094);
    add_op(k_short, spi_ctl_pkg::addr_led, 8'h0f);
    add_rd(spi_ctl_pkg::addr_led);
    // downstream routing
    for (int v = 0; v <= 9; v++)
      add_op(k_pass, spi_ctl_pkg::addr_port_sel, 8'(v));
    // heartbeat phase, led bit 0 unknown until cleared
    add_wr(spi_ctl_pkg::addr_led, 8'h08, 1'b1);
    add_op(k_hb, spi_ctl_pkg::addr_led, 8'h00);
    add_wr(spi_ctl_pkg::addr_port_sel, rand_byte(), 1'b0);
    add_op(k_hb, spi_ctl_pkg::addr_led, 8'h00);
    add_rd(spi_ctl_pkg::addr_port_sel);
    add_wr(spi_ctl_pkg::addr_led, 8'h80, 1'b0);
    add_wr(spi_ctl_pkg::addr_led, 8'h10, 1'b1);
    add_op(k_hold, spi_ctl_pkg::addr_led, 8'h00);

    limit = tbl.size() * (frame_cyc + 4 * hb_div);

    @(posedge arst_n);
    @(posedge cs);
    #1;
    check_reg({7'b0, oe_4094}, 8'h00, "oe_4094 after reset");
    check_port(port_ss, ~port_pol, "port_ss after reset");

    foreach (tbl[i])
      apply(tbl[i]);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
src/spi_ctl_pkg.sv
src/spi_pin_sync.sv
src/spi_reg_slave.sv
src/heartbeat_pulser.sv
src/reg_arbiter.sv
src/ctl_reg_file.sv
src/spi_port_mux.sv
src/panel_ctl_top.sv
dv/tb_clock_gen.sv
dv/tb_panel_ctl.sv

// File: src/ctl_reg_file.sv
/*
  led, port select and 4094 driver registers.
  writes land the cycle after wr_en. unknown reads return 0.
*/
`timescale 1ns/1ns
`default_nettype none

module ctl_reg_file (
  input  wire                    cs,
  input  wire                    arst_n,
  input  wire                    wr_en,
  input  spi_ctl_pkg::reg_wr_t   wr,
  input  spi_ctl_pkg::reg_addr_t rd_addr,
  output spi_ctl_pkg::reg_data_t rd_data,
  output logic [3:0]             led,
  output logic [7:0]             port_sel,
  output logic [3:0]             drv_4094
);

  // set bits low nibble, clear bits high nibble
  // any position with both turns the write into a toggle
  function automatic logic [3:0] nib_update(
    input logic [3:0]             cur,
    input spi_ctl_pkg::reg_data_t d
  );
    logic [3:0] set_b;
    logic [3:0] clr_b;
    logic [3:0] both_b;
    set_b  = d[3:0];
    clr_b  = d[7:4];
    both_b = set_b & clr_b;
    if (|both_b)
      nib_update = cur ^ both_b;
    else
      nib_update = (cur | set_b) & ~clr_b;   // clear wins
  endfunction

  //////////////////////////////////////////////////
  // write side

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      led      <= spi_ctl_pkg::led_init;
      port_sel <= '0;
      drv_4094 <= '0;
    end
    else if (wr_en)
    begin
      case (wr.addr)
        spi_ctl_pkg::addr_led:      led      <= nib_update(led, wr.data);
        spi_ctl_pkg::addr_port_sel: port_sel <= wr.data;
        spi_ctl_pkg::addr_drv_4094: drv_4094 <= nib_update(drv_4094, wr.data);
        spi_ctl_pkg::addr_soft_rst:
        begin
          led      <= '0;
          port_sel <= '0;
        end
        // power rails not yet confirmed, leds off
        spi_ctl_pkg::addr_pwr_clear: led <= '0;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read side, combinational for the slave

  always_comb
  begin
    case (rd_addr)
      spi_ctl_pkg::addr_led:      rd_data = {4'h0, led};
      spi_ctl_pkg::addr_port_sel: rd_data = port_sel;
      spi_ctl_pkg::addr_drv_4094: rd_data = {4'h0, drv_4094};
      default:                    rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/heartbeat_pulser.sv
/*
  led heartbeat source, one hb_req pulse per HEARTBEAT_DIV cycles.
  runs only while led bit 3 is set.
*/
`timescale 1ns/1ns
`default_nettype none

module heartbeat_pulser #(
  parameter int HEARTBEAT_DIV = 1024
) (
  input  wire        cs,
  input  wire        arst_n,
  input  wire  [3:0] led,
  output logic       hb_req
);

  localparam int div_w = (HEARTBEAT_DIV > 1) ? $clog2(HEARTBEAT_DIV) : 1;

  logic [div_w-1:0] div_q;

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      div_q  <= '0;
      hb_req <= 1'b0;
    end
    else if (!led[3])
    begin
      // disabled, restart the period on next enable
      div_q  <= '0;
      hb_req <= 1'b0;
    end
    else if (div_q == div_w'(HEARTBEAT_DIV - 1))
    begin
      div_q  <= '0;
      hb_req <= 1'b1;
    end
    else
    begin
      div_q  <= div_q + 1'b1;
      hb_req <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/panel_ctl_top.sv
/*
  control panel top. all logic on cs, host spi is oversampled.
  host sclk half period must be at least 4 cs cycles.
*/
`timescale 1ns/1ns
`default_nettype none

module panel_ctl_top #(
  parameter int                     HEARTBEAT_DIV    = 1024,
  parameter spi_ctl_pkg::port_vec_t PORT_CS_POLARITY = 8'h01
) (
  input  wire                    cs,
  input  wire                    arst_n,
  input  spi_ctl_pkg::spi_pins_t host,
  input  wire                    spi_ss2_n,
  input  spi_ctl_pkg::port_vec_t port_miso,
  output logic                   spi_miso,
  output logic [3:0]             led,
  output logic                   oe_4094,
  output spi_ctl_pkg::port_vec_t port_ss,
  output spi_ctl_pkg::port_vec_t port_sclk,
  output spi_ctl_pkg::port_vec_t port_mosi
);

  logic mosi, sclk_rise, sclk_fall, ss_fall, ss_rise, ss_active;
  logic slave_miso;
  logic wr_req, hb_req, wr_en;
  spi_ctl_pkg::reg_wr_t   slave_wr;
  spi_ctl_pkg::reg_wr_t   arb_wr;
  spi_ctl_pkg::reg_addr_t rd_addr;
  spi_ctl_pkg::reg_data_t rd_data;
  logic [7:0] port_sel;
  logic [3:0] drv_4094;

  //////////////////////////////////////////////////
  // host link

  spi_pin_sync u_sync (
    .cs, .arst_n, .pins(host), .mosi, .sclk_rise, .sclk_fall,
    .ss_fall, .ss_rise, .ss_active
  );

  spi_reg_slave #(.FRAME_BITS(spi_ctl_pkg::frame_bits)) u_slave (
    .cs, .arst_n, .mosi, .sclk_rise, .sclk_fall, .ss_fall, .ss_rise,
    .ss_active, .rd_addr, .rd_data, .miso(slave_miso), .wr_req, .wr(slave_wr)
  );

  //////////////////////////////////////////////////
  // register writers and the register file

  heartbeat_pulser #(.HEARTBEAT_DIV(HEARTBEAT_DIV)) u_hb (
    .cs, .arst_n, .led, .hb_req
  );

  reg_arbiter u_arb (
    .cs, .arst_n, .wr_req, .wr(slave_wr), .hb_req, .wr_en, .wr_out(arb_wr)
  );

  ctl_reg_file u_regs (
    .cs, .arst_n, .wr_en, .wr(arb_wr), .rd_addr, .rd_data,
    .led, .port_sel, .drv_4094
  );

  // 4094 output enable on driver bit 0
  assign oe_4094 = drv_4094[0];

  //////////////////////////////////////////////////
  // downstream ports, raw pins

  spi_port_mux #(.PORT_CS_POLARITY(PORT_CS_POLARITY)) u_mux (
    .pins(host), .ss2_n(spi_ss2_n), .port_sel, .slave_miso, .port_miso,
    .port_ss, .port_sclk, .port_mosi, .host_miso(spi_miso)
  );

endmodule

`default_nettype wire

// File: src/reg_arbiter.sv
/*
  single register write port, spi first, heartbeat second.
  a losing heartbeat waits in one flag; repeats merge into it.
*/
`timescale 1ns/1ns
`default_nettype none

module reg_arbiter (
  input  wire                  cs,
  input  wire                  arst_n,
  input  wire                  wr_req,
  input  spi_ctl_pkg::reg_wr_t wr,
  input  wire                  hb_req,
  output logic                 wr_en,
  output spi_ctl_pkg::reg_wr_t wr_out
);

  // led toggle of bit 0: set and clear both on bit 0
  localparam spi_ctl_pkg::reg_wr_t hb_wr = '{
    addr: spi_ctl_pkg::addr_led,
    data: 8'h11
  };

  logic hb_pend_q;
  logic hb_want;

  assign hb_want = hb_req | hb_pend_q;

  // combinational grant keeps spi latency fixed
  assign wr_en  = wr_req | hb_want;
  assign wr_out = wr_req ? wr : hb_wr;

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
      hb_pend_q <= 1'b0;
    else
      hb_pend_q <= hb_want & wr_req;   // held only while spi wins
  end

endmodule

`default_nettype wire

// File: src/spi_ctl_pkg.sv
/*
  shared sizes, register map and bundles for the control panel.
  4-bit registers sit in the low nibble of reg_data_t.
*/
`default_nettype none

package spi_ctl_pkg;

  // frame and port counts
  localparam int frame_bits = 16;
  localparam int port_count = 8;

  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;
  typedef logic [port_count-1:0] port_vec_t;

  //////////////////////////////////////////////////
  // register map

  localparam reg_addr_t addr_pwr_clear = 8'd6;
  localparam reg_addr_t addr_led       = 8'd7;
  localparam reg_addr_t addr_port_sel  = 8'd8;
  localparam reg_addr_t addr_drv_4094  = 8'd9;
  localparam reg_addr_t addr_soft_rst  = 8'd11;

  // led0 lit out of reset
  localparam logic [3:0] led_init = 4'b0001;

  //////////////////////////////////////////////////
  // bundles

  // one register write, address in the high byte
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t data;
  } reg_wr_t;

  // host pin set, mode 0 only
  typedef struct packed {
    logic sclk;
    logic ss_n;
    logic mosi;
  } spi_pins_t;

endpackage

`default_nettype wire

// File: src/spi_pin_sync.sv
/*
  brings the host spi pins into the cs domain.
  strobes lag the pins by 3 cs cycles; sclk half period must be >= 4 cs.
*/
`timescale 1ns/1ns
`default_nettype none

module spi_pin_sync (
  input  wire                   cs,
  input  wire                   arst_n,
  input  spi_ctl_pkg::spi_pins_t pins,
  output logic                  mosi,
  output logic                  sclk_rise,
  output logic                  sclk_fall,
  output logic                  ss_fall,
  output logic                  ss_rise,
  output logic                  ss_active
);

  // three stages, third one is the edge reference
  spi_ctl_pkg::spi_pins_t s1_q, s2_q, s3_q;

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // idle bus: sclk low, select high
      s1_q      <= '{sclk: 1'b0, ss_n: 1'b1, mosi: 1'b0};
      s2_q      <= '{sclk: 1'b0, ss_n: 1'b1, mosi: 1'b0};
      s3_q      <= '{sclk: 1'b0, ss_n: 1'b1, mosi: 1'b0};
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      ss_fall   <= 1'b0;
      ss_rise   <= 1'b0;
    end
    else
    begin
      s1_q      <= pins;
      s2_q      <= s1_q;
      s3_q      <= s2_q;
      // registered compare, one edge-detect cycle
      sclk_rise <= s2_q.sclk & ~s3_q.sclk;
      sclk_fall <= ~s2_q.sclk & s3_q.sclk;
      ss_fall   <= ~s2_q.ss_n & s3_q.ss_n;
      ss_rise   <= s2_q.ss_n & ~s3_q.ss_n;
    end
  end

  // same stage as the strobes
  assign mosi      = s3_q.mosi;
  assign ss_active = ~s3_q.ss_n;

endmodule

`default_nettype wire

// File: src/spi_port_mux.sv
/*
  routes the second-select spi to one downstream port, purely combinational.
  port_sel 1..8 picks port 0..7, anything else picks none.
*/
`timescale 1ns/1ns
`default_nettype none

module spi_port_mux #(
  parameter spi_ctl_pkg::port_vec_t PORT_CS_POLARITY = 8'h01
) (
  input  spi_ctl_pkg::spi_pins_t pins,
  input  wire                    ss2_n,
  input  wire  [7:0]             port_sel,
  input  wire                    slave_miso,
  input  spi_ctl_pkg::port_vec_t port_miso,
  output spi_ctl_pkg::port_vec_t port_ss,
  output spi_ctl_pkg::port_vec_t port_sclk,
  output spi_ctl_pkg::port_vec_t port_mosi,
  output logic                   host_miso
);

  spi_ctl_pkg::port_vec_t sel_hot;
  spi_ctl_pkg::port_vec_t ss_on;

  // one-hot decode, value 0 means no port
  always_comb
  begin
    sel_hot = '0;
    if ((port_sel != 8'd0) && (port_sel <= 8'(spi_ctl_pkg::port_count)))
      sel_hot[port_sel[2:0] - 3'd1] = 1'b1;
  end

  assign ss_on = sel_hot & {spi_ctl_pkg::port_count{~ss2_n}};

  // polarity bit 1 drives the strobe high when selected
  assign port_ss = ss_on ^ ~PORT_CS_POLARITY;

  // only the chosen port sees clock and data
  assign port_sclk = sel_hot & {spi_ctl_pkg::port_count{pins.sclk}};
  assign port_mosi = sel_hot & {spi_ctl_pkg::port_count{pins.mosi}};

  // register slave owns miso unless ss2 is down
  assign host_miso = ss2_n ? slave_miso : |(sel_hot & port_miso);

endmodule

`default_nettype wire

// File: src/spi_reg_slave.sv
/*
  mode 0 register slave, msb first: address byte then data byte.
  only frames of exactly FRAME_BITS bits produce a write.
  readback leaves on miso during the second byte, 0 elsewhere.
*/
`timescale 1ns/1ns
`default_nettype none

module spi_reg_slave #(
  parameter int FRAME_BITS = 16
) (
  input  wire                    cs,
  input  wire                    arst_n,
  input  wire                    mosi,
  input  wire                    sclk_rise,
  input  wire                    sclk_fall,
  input  wire                    ss_fall,
  input  wire                    ss_rise,
  input  wire                    ss_active,
  output spi_ctl_pkg::reg_addr_t rd_addr,
  input  spi_ctl_pkg::reg_data_t rd_data,
  output logic                   miso,
  output logic                   wr_req,
  output spi_ctl_pkg::reg_wr_t   wr
);

  // one spare bit so long frames saturate instead of wrapping
  localparam int cnt_w = $clog2(FRAME_BITS) + 1;

  logic [FRAME_BITS-1:0] shift_q;
  logic [cnt_w-1:0]      count_q;
  spi_ctl_pkg::reg_data_t rd_sh_q;

  // address complete on the 8th rise
  logic addr_done;
  assign addr_done = sclk_rise && (count_q == cnt_w'(7));

  // low seven bits already in, mosi carries the last one
  assign rd_addr = {shift_q[6:0], mosi};

  //////////////////////////////////////////////////
  // frame shifter and bit counter

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      shift_q <= '0;
      count_q <= '0;
    end
    else if (ss_fall)
    begin
      shift_q <= '0;
      count_q <= '0;
    end
    else if (ss_active && sclk_rise)
    begin
      shift_q <= {shift_q[FRAME_BITS-2:0], mosi};
      if (count_q != '1)
        count_q <= count_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // readback shifter

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
      rd_sh_q <= '0;
    else if (ss_fall)
      rd_sh_q <= '0;
    else if (ss_active && addr_done)
      rd_sh_q <= rd_data;
    // fall after bit 8 keeps the msb for the 9th rise
    else if (ss_active && sclk_fall && (count_q > cnt_w'(8)))
      rd_sh_q <= {rd_sh_q[6:0], 1'b0};
  end

  // zero fill drains to 0 after the slot
  assign miso = rd_sh_q[7];

  //////////////////////////////////////////////////
  // write request on select release

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
      wr_req <= 1'b0;
    else
      wr_req <= ss_rise && (count_q == cnt_w'(FRAME_BITS));
  end

  // shifter holds until the next ss_fall, so payload stays valid
  assign wr = shift_q[FRAME_BITS-1 -: $bits(spi_ctl_pkg::reg_wr_t)];

endmodule

`default_nettype wire
